/* hw/mipsPkg.sv */
package mipsPkg;

    localparam int XLen         = 32;
    localparam int RegAddrWidth = 5;
    localparam int AluCtrlWidth = 4;

    // alu operations
    localparam logic [AluCtrlWidth-1:0] AluAdd = 4'd0;
    localparam logic [AluCtrlWidth-1:0] AluSub = 4'd1;
    localparam logic [AluCtrlWidth-1:0] AluAnd = 4'd2;
    localparam logic [AluCtrlWidth-1:0] AluOr  = 4'd3;
    localparam logic [AluCtrlWidth-1:0] AluXor = 4'd4;
    localparam logic [AluCtrlWidth-1:0] AluSlt = 4'd5;
    localparam logic [AluCtrlWidth-1:0] AluSll = 4'd6;
    localparam logic [AluCtrlWidth-1:0] AluLui = 4'd7;

    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpJ       = 6'h02;
    localparam logic [5:0] OpBeq     = 6'h04;
    localparam logic [5:0] OpBne     = 6'h05;
    localparam logic [5:0] OpAddiu   = 6'h09;
    localparam logic [5:0] OpSlti    = 6'h0A;
    localparam logic [5:0] OpAndi    = 6'h0C;
    localparam logic [5:0] OpOri     = 6'h0D;
    localparam logic [5:0] OpLui     = 6'h0F;
    localparam logic [5:0] OpLw      = 6'h23;
    localparam logic [5:0] OpSw      = 6'h2B;

    // funct field of the special opcode
    localparam logic [5:0] FunctSll  = 6'h00;
    localparam logic [5:0] FunctAddu = 6'h21;
    localparam logic [5:0] FunctSubu = 6'h23;
    localparam logic [5:0] FunctAnd  = 6'h24;
    localparam logic [5:0] FunctOr   = 6'h25;
    localparam logic [5:0] FunctXor  = 6'h26;
    localparam logic [5:0] FunctSlt  = 6'h2A;

    // operand source picked in decode
    localparam logic [1:0] FwdReg  = 2'd0;
    localparam logic [1:0] FwdExec = 2'd1;
    localparam logic [1:0] FwdMem  = 2'd2;
    localparam logic [1:0] FwdWb   = 2'd3;

    typedef union packed {
        struct packed {
            logic [5:0]              opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [RegAddrWidth-1:0] rd;
            logic [4:0]              shamt;
            logic [5:0]              funct;
        } rType;
        struct packed {
            logic [5:0]              opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [15:0]             imm16;
        } iType;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target26;
        } jType;
    } instrWord_u;

endpackage

/* hw/regFile.sv */
module regFile import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic [RegAddrWidth-1:0] raddr1_i,
    input  logic [RegAddrWidth-1:0] raddr2_i,
    input  logic                    we_i,
    input  logic [RegAddrWidth-1:0] waddr_i,
    input  logic [XLen-1:0]         wdata_i,
    output logic [XLen-1:0]         rdata1_o,
    output logic [XLen-1:0]         rdata2_o
);

    // $0 has no storage
    logic [XLen-1:0] regs [1:2**RegAddrWidth-1];

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int k = 1; k < 2**RegAddrWidth; k++) begin
                regs[k] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* hw/fetchStage.sv */
module fetchStage import mipsPkg::*; #(
    parameter logic [XLen-1:0] ResetPc = 32'hBFC00000
) (
    input  logic            clk,
    input  logic            rstN_i,
    input  logic            stallF_i,
    input  logic            stallD_i,
    input  logic            flushD_i,
    input  logic            branchTakenE_i,
    input  logic [XLen-1:0] branchTargetE_i,
    input  logic            jumpD_i,
    input  logic [XLen-1:0] jumpTargetD_i,
    input  logic [XLen-1:0] instr_i,
    output logic [XLen-1:0] instAddr_o,
    output logic            instEn_o,
    output logic [XLen-1:0] pcD_o,
    output logic [XLen-1:0] instrD_o
);

    logic [XLen-1:0] pcF;
    logic [XLen-1:0] nextPc;

    always_comb begin
        if (branchTakenE_i) begin
            nextPc = branchTargetE_i;   // branch in E wins over a jump in D
        end else if (jumpD_i) begin
            nextPc = jumpTargetD_i;
        end else if (stallF_i) begin
            nextPc = pcF;
        end else begin
            nextPc = pcF + XLen'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pcF <= ResetPc;
        end else begin
            pcF <= nextPc;
        end
    end

    assign instAddr_o = pcF;
    assign instEn_o   = ~stallF_i;

    // fetch to decode
    always_ff @(posedge clk) begin
        if (!rstN_i || flushD_i) begin
            instrD_o <= '0;   // all-zero word is sll $0 i.e. a nop
        end else if (!stallD_i) begin
            instrD_o <= instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD_i) begin
            pcD_o <= pcF;
        end
    end

endmodule

/* hw/decodeStage.sv */
module decodeStage import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    bubbleE_i,
    input  logic [XLen-1:0]         pcD_i,
    input  logic [XLen-1:0]         instrD_i,
    input  logic [XLen-1:0]         rd1_i,
    input  logic [XLen-1:0]         rd2_i,
    input  logic [1:0]              fwdA_i,
    input  logic [1:0]              fwdB_i,
    input  logic [XLen-1:0]         aluResultE_i,
    input  logic [XLen-1:0]         resultM_i,
    input  logic [XLen-1:0]         wbDataW_i,
    output logic [RegAddrWidth-1:0] rsD_o,
    output logic [RegAddrWidth-1:0] rtD_o,
    output logic                    jumpD_o,
    output logic [XLen-1:0]         jumpTargetD_o,
    output logic [XLen-1:0]         pcE_o,
    output logic [XLen-1:0]         instrE_o,
    output logic [XLen-1:0]         srcAE_o,
    output logic [XLen-1:0]         srcBE_o,
    output logic [XLen-1:0]         immE_o,
    output logic [AluCtrlWidth-1:0] aluCtrlE_o,
    output logic                    useImmE_o,
    output logic                    branchEqE_o,
    output logic                    branchNeE_o,
    output logic                    regWriteE_o,
    output logic                    memReadE_o,
    output logic                    memWriteE_o,
    output logic [RegAddrWidth-1:0] destE_o
);

    instrWord_u              ins;
    logic [XLen-1:0]         pcPlus4;
    logic [XLen-1:0]         imm;
    logic [XLen-1:0]         srcA;
    logic [XLen-1:0]         srcB;
    logic [RegAddrWidth-1:0] dest;
    logic [AluCtrlWidth-1:0] aluCtrl;
    logic useRs, useRt, useImm, signExt, rtIsDest;
    logic branchEq, branchNe, regWrite, memRead, memWrite;

    function automatic logic [XLen-1:0] pickSrc(input logic [1:0] sel,
                                                input logic [XLen-1:0] regVal);
        case (sel)
            FwdExec: return aluResultE_i;
            FwdMem:  return resultM_i;
            FwdWb:   return wbDataW_i;
            default: return regVal;
        endcase
    endfunction

    assign ins = instrD_i;

    always_comb begin
        aluCtrl  = AluAdd;
        useRs    = 1'b1;
        useRt    = 1'b0;
        useImm   = 1'b1;
        signExt  = 1'b1;
        rtIsDest = 1'b1;
        branchEq = 1'b0;
        branchNe = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        jumpD_o  = 1'b0;
        case (ins.rType.opcode)
            OpSpecial: begin
                useRt    = 1'b1;
                useImm   = 1'b0;
                rtIsDest = 1'b0;
                regWrite = 1'b1;
                case (ins.rType.funct)
                    FunctAddu: aluCtrl = AluAdd;
                    FunctSubu: aluCtrl = AluSub;
                    FunctAnd:  aluCtrl = AluAnd;
                    FunctOr:   aluCtrl = AluOr;
                    FunctXor:  aluCtrl = AluXor;
                    FunctSlt:  aluCtrl = AluSlt;
                    FunctSll:  aluCtrl = AluSll;
                    default:   regWrite = 1'b0;   // unknown funct retires quietly
                endcase
            end
            OpAddiu: regWrite = 1'b1;
            OpSlti: begin
                regWrite = 1'b1;
                aluCtrl  = AluSlt;
            end
            OpAndi: begin
                regWrite = 1'b1;
                aluCtrl  = AluAnd;
                signExt  = 1'b0;
            end
            OpOri: begin
                regWrite = 1'b1;
                aluCtrl  = AluOr;
                signExt  = 1'b0;
            end
            OpLui: begin
                regWrite = 1'b1;
                aluCtrl  = AluLui;
                useRs    = 1'b0;
            end
            OpLw: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            OpSw: begin
                useRt    = 1'b1;   // store data
                memWrite = 1'b1;
            end
            OpBeq: begin
                useRt    = 1'b1;
                branchEq = 1'b1;
            end
            OpBne: begin
                useRt    = 1'b1;
                branchNe = 1'b1;
            end
            OpJ: begin
                useRs   = 1'b0;   // rs bits belong to the target here
                jumpD_o = 1'b1;
            end
            default: useRs = 1'b0;
        endcase
    end

    // unused source fields read as $0 so they never forward or stall
    assign rsD_o = useRs ? ins.iType.rs : '0;
    assign rtD_o = useRt ? ins.iType.rt : '0;

    assign imm  = signExt ? {{16{ins.iType.imm16[15]}}, ins.iType.imm16}
                          : {16'h0000, ins.iType.imm16};
    assign dest = rtIsDest ? ins.iType.rt : ins.rType.rd;
    assign srcA = pickSrc(fwdA_i, rd1_i);
    assign srcB = pickSrc(fwdB_i, rd2_i);

    assign pcPlus4       = pcD_i + XLen'(4);
    assign jumpTargetD_o = {pcPlus4[XLen-1:28], ins.jType.target26, 2'b00};

    // decode to execute
    always_ff @(posedge clk) begin
        if (!rstN_i || bubbleE_i) begin
            regWriteE_o <= 1'b0;
            memReadE_o  <= 1'b0;
            memWriteE_o <= 1'b0;
            branchEqE_o <= 1'b0;
            branchNeE_o <= 1'b0;
        end else begin
            regWriteE_o <= regWrite;
            memReadE_o  <= memRead;
            memWriteE_o <= memWrite;
            branchEqE_o <= branchEq;
            branchNeE_o <= branchNe;
        end
    end

    always_ff @(posedge clk) begin
        pcE_o      <= pcD_i;
        instrE_o   <= instrD_i;
        srcAE_o    <= srcA;
        srcBE_o    <= srcB;
        immE_o     <= imm;
        aluCtrlE_o <= aluCtrl;
        useImmE_o  <= useImm;
        destE_o    <= dest;
    end

endmodule

/* hw/executeStage.sv */
module executeStage import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic [XLen-1:0]         pcE_i,
    input  logic [XLen-1:0]         instrE_i,
    input  logic [XLen-1:0]         srcAE_i,
    input  logic [XLen-1:0]         srcBE_i,
    input  logic [XLen-1:0]         immE_i,
    input  logic [AluCtrlWidth-1:0] aluCtrlE_i,
    input  logic                    useImmE_i,
    input  logic                    branchEqE_i,
    input  logic                    branchNeE_i,
    input  logic                    regWriteE_i,
    input  logic                    memReadE_i,
    input  logic                    memWriteE_i,
    input  logic [RegAddrWidth-1:0] destE_i,
    output logic [XLen-1:0]         aluResultE_o,
    output logic                    branchTakenE_o,
    output logic [XLen-1:0]         branchTargetE_o,
    output logic [XLen-1:0]         pcM_o,
    output logic [XLen-1:0]         aluResultM_o,
    output logic [XLen-1:0]         storeDataM_o,
    output logic                    regWriteM_o,
    output logic                    memReadM_o,
    output logic                    memWriteM_o,
    output logic [RegAddrWidth-1:0] destM_o
);

    instrWord_u      ins;
    logic [XLen-1:0] opB;
    logic            operandsEq;

    assign ins = instrE_i;
    assign opB = useImmE_i ? immE_i : srcBE_i;

    always_comb begin
        case (aluCtrlE_i)
            AluAdd:  aluResultE_o = srcAE_i + opB;
            AluSub:  aluResultE_o = srcAE_i - opB;
            AluAnd:  aluResultE_o = srcAE_i & opB;
            AluOr:   aluResultE_o = srcAE_i | opB;
            AluXor:  aluResultE_o = srcAE_i ^ opB;
            AluSlt:  aluResultE_o = {{(XLen-1){1'b0}}, $signed(srcAE_i) < $signed(opB)};
            AluSll:  aluResultE_o = srcBE_i << ins.rType.shamt;   // shifts rt
            AluLui:  aluResultE_o = {opB[15:0], 16'h0000};
            default: aluResultE_o = '0;
        endcase
    end

    // beq/bne compare the raw register operands
    assign operandsEq      = (srcAE_i == srcBE_i);
    assign branchTakenE_o  = (branchEqE_i & operandsEq) | (branchNeE_i & ~operandsEq);
    assign branchTargetE_o = pcE_i + XLen'(4) + {immE_i[XLen-3:0], 2'b00};

    // execute to memory
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            regWriteM_o <= 1'b0;
            memReadM_o  <= 1'b0;
            memWriteM_o <= 1'b0;
        end else begin
            regWriteM_o <= regWriteE_i;
            memReadM_o  <= memReadE_i;
            memWriteM_o <= memWriteE_i;
        end
    end

    always_ff @(posedge clk) begin
        pcM_o        <= pcE_i;
        aluResultM_o <= aluResultE_o;
        storeDataM_o <= srcBE_i;
        destM_o      <= destE_i;
    end

endmodule

/* hw/memoryStage.sv */
module memoryStage import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic [XLen-1:0]         pcM_i,
    input  logic [XLen-1:0]         aluResultM_i,
    input  logic [XLen-1:0]         storeDataM_i,
    input  logic                    regWriteM_i,
    input  logic                    memReadM_i,
    input  logic                    memWriteM_i,
    input  logic [RegAddrWidth-1:0] destM_i,
    input  logic [XLen-1:0]         memRdata_i,
    output logic                    memEn_o,
    output logic                    memWe_o,
    output logic [XLen-1:0]         memAddr_o,
    output logic [XLen-1:0]         memWdata_o,
    output logic [XLen-1:0]         resultM_o,
    output logic                    wbWeW_o,
    output logic [RegAddrWidth-1:0] wbRegW_o,
    output logic [XLen-1:0]         wbDataW_o,
    output logic [XLen-1:0]         wbPc_o
);

    assign memEn_o    = memReadM_i | memWriteM_i;
    assign memWe_o    = memWriteM_i;   // written on the next rising edge
    assign memAddr_o  = aluResultM_i;
    assign memWdata_o = storeDataM_i;

    // load data arrives in the same cycle
    assign resultM_o = memReadM_i ? memRdata_i : aluResultM_i;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            wbWeW_o <= 1'b0;
        end else begin
            wbWeW_o <= regWriteM_i && (destM_i != '0);   // $0 writes never show
        end
    end

    always_ff @(posedge clk) begin
        wbRegW_o  <= destM_i;
        wbDataW_o <= resultM_o;
        wbPc_o    <= pcM_i;
    end

endmodule

/* hw/hazardUnit.sv */
module hazardUnit import mipsPkg::*; (
    input  logic [RegAddrWidth-1:0] rsD_i,
    input  logic [RegAddrWidth-1:0] rtD_i,
    input  logic [RegAddrWidth-1:0] destE_i,
    input  logic                    regWriteE_i,
    input  logic                    memReadE_i,
    input  logic [RegAddrWidth-1:0] destM_i,
    input  logic                    regWriteM_i,
    input  logic [RegAddrWidth-1:0] destW_i,
    input  logic                    regWriteW_i,
    input  logic                    branchTakenE_i,
    output logic [1:0]              fwdA_o,
    output logic [1:0]              fwdB_o,
    output logic                    stallF_o,
    output logic                    stallD_o,
    output logic                    bubbleE_o,
    output logic                    flushD_o
);

    logic loadUse;

    // nearest producer wins
    function automatic logic [1:0] fwdFor(input logic [RegAddrWidth-1:0] src);
        if (src == '0) return FwdReg;
        if (regWriteE_i && destE_i == src) return FwdExec;
        if (regWriteM_i && destM_i == src) return FwdMem;
        if (regWriteW_i && destW_i == src) return FwdWb;
        return FwdReg;
    endfunction

    always_comb begin
        fwdA_o = fwdFor(rsD_i);
        fwdB_o = fwdFor(rtD_i);
    end

    // load in E has no data yet, hold D one cycle and take it from M
    assign loadUse = memReadE_i && regWriteE_i && (destE_i != '0)
                     && (destE_i == rsD_i || destE_i == rtD_i);

    assign stallF_o  = loadUse;
    assign stallD_o  = loadUse;
    assign bubbleE_o = loadUse;
    assign flushD_o  = branchTakenE_i & ~loadUse;   // kills the word behind the delay slot

endmodule

/* hw/mipsCore.sv */
module mipsCore import mipsPkg::*; #(
    parameter logic [XLen-1:0] ResetPc = 32'hBFC00000
) (
    input  logic                    clk,
    input  logic                    rstN_i,
    output logic [XLen-1:0]         instAddr_o,
    output logic                    instEn_o,
    input  logic [XLen-1:0]         instr_i,
    output logic                    memEn_o,
    output logic                    memWe_o,
    output logic [XLen-1:0]         memAddr_o,
    output logic [XLen-1:0]         memWdata_o,
    input  logic [XLen-1:0]         memRdata_i,
    output logic [XLen-1:0]         wbPc_o,
    output logic                    wbWen_o,
    output logic [RegAddrWidth-1:0] wbWnum_o,
    output logic [XLen-1:0]         wbWdata_o
);

    logic                    stallF, stallD, bubbleE, flushD;
    logic [1:0]              fwdA, fwdB;
    logic                    branchTakenE, jumpD;
    logic [XLen-1:0]         branchTargetE, jumpTargetD, pcD, instrD, rd1, rd2;
    logic [RegAddrWidth-1:0] rsD, rtD, destE, destM, wbRegW;
    logic [XLen-1:0]         pcE, instrE, srcAE, srcBE, immE, aluResultE;
    logic [AluCtrlWidth-1:0] aluCtrlE;
    logic useImmE, branchEqE, branchNeE, regWriteE, memReadE, memWriteE;
    logic [XLen-1:0]         pcM, aluResultM, storeDataM, resultM, wbDataW;
    logic                    regWriteM, memReadM, memWriteM, wbWeW;

    fetchStage #(.ResetPc(ResetPc)) uFetch (
        .clk(clk), .rstN_i(rstN_i),
        .stallF_i(stallF), .stallD_i(stallD), .flushD_i(flushD),
        .branchTakenE_i(branchTakenE), .branchTargetE_i(branchTargetE),
        .jumpD_i(jumpD), .jumpTargetD_i(jumpTargetD), .instr_i(instr_i),
        .instAddr_o(instAddr_o), .instEn_o(instEn_o), .pcD_o(pcD), .instrD_o(instrD)
    );

    decodeStage uDecode (
        .clk(clk), .rstN_i(rstN_i), .bubbleE_i(bubbleE),
        .pcD_i(pcD), .instrD_i(instrD), .rd1_i(rd1), .rd2_i(rd2),
        .fwdA_i(fwdA), .fwdB_i(fwdB),
        .aluResultE_i(aluResultE), .resultM_i(resultM), .wbDataW_i(wbDataW),
        .rsD_o(rsD), .rtD_o(rtD), .jumpD_o(jumpD), .jumpTargetD_o(jumpTargetD),
        .pcE_o(pcE), .instrE_o(instrE), .srcAE_o(srcAE), .srcBE_o(srcBE), .immE_o(immE),
        .aluCtrlE_o(aluCtrlE), .useImmE_o(useImmE),
        .branchEqE_o(branchEqE), .branchNeE_o(branchNeE), .regWriteE_o(regWriteE),
        .memReadE_o(memReadE), .memWriteE_o(memWriteE), .destE_o(destE)
    );

    regFile uRegFile (
        .clk(clk), .rstN_i(rstN_i), .raddr1_i(rsD), .raddr2_i(rtD),
        .we_i(wbWeW), .waddr_i(wbRegW), .wdata_i(wbDataW),
        .rdata1_o(rd1), .rdata2_o(rd2)
    );

    executeStage uExecute (
        .clk(clk), .rstN_i(rstN_i),
        .pcE_i(pcE), .instrE_i(instrE), .srcAE_i(srcAE), .srcBE_i(srcBE), .immE_i(immE),
        .aluCtrlE_i(aluCtrlE), .useImmE_i(useImmE),
        .branchEqE_i(branchEqE), .branchNeE_i(branchNeE), .regWriteE_i(regWriteE),
        .memReadE_i(memReadE), .memWriteE_i(memWriteE), .destE_i(destE),
        .aluResultE_o(aluResultE), .branchTakenE_o(branchTakenE),
        .branchTargetE_o(branchTargetE),
        .pcM_o(pcM), .aluResultM_o(aluResultM), .storeDataM_o(storeDataM),
        .regWriteM_o(regWriteM), .memReadM_o(memReadM), .memWriteM_o(memWriteM),
        .destM_o(destM)
    );

    memoryStage uMemory (
        .clk(clk), .rstN_i(rstN_i),
        .pcM_i(pcM), .aluResultM_i(aluResultM), .storeDataM_i(storeDataM),
        .regWriteM_i(regWriteM), .memReadM_i(memReadM), .memWriteM_i(memWriteM),
        .destM_i(destM), .memRdata_i(memRdata_i),
        .memEn_o(memEn_o), .memWe_o(memWe_o), .memAddr_o(memAddr_o),
        .memWdata_o(memWdata_o), .resultM_o(resultM),
        .wbWeW_o(wbWeW), .wbRegW_o(wbRegW), .wbDataW_o(wbDataW), .wbPc_o(wbPc_o)
    );

    hazardUnit uHazard (
        .rsD_i(rsD), .rtD_i(rtD),
        .destE_i(destE), .regWriteE_i(regWriteE), .memReadE_i(memReadE),
        .destM_i(destM), .regWriteM_i(regWriteM),
        .destW_i(wbRegW), .regWriteW_i(wbWeW), .branchTakenE_i(branchTakenE),
        .fwdA_o(fwdA), .fwdB_o(fwdB), .stallF_o(stallF), .stallD_o(stallD),
        .bubbleE_o(bubbleE), .flushD_o(flushD)
    );

    // trace is the writeback register itself
    assign wbWen_o   = wbWeW;
    assign wbWnum_o  = wbRegW;
    assign wbWdata_o = wbDataW;

endmodule

/* verif/tbMipsCore.sv */
module tbMipsCore import mipsPkg::*; ();

    localparam logic [XLen-1:0] ResetPc = 32'hBFC00000;
    localparam int DataBase      = 256;   // golden word index of the data image
    localparam int EventBase     = 512;   // golden word index of the trace list
    localparam int DataWords     = 16;
    localparam int MaxEntries    = 160;
    localparam int TimeoutCycles = 1000;
    localparam int DrainCycles   = 20;
    localparam int LoadUseStalls = 2;     // load-use pairs in the program image

    logic                    clk;
    logic                    rstN;
    logic [XLen-1:0]         instAddr;
    logic                    instEn;
    logic [XLen-1:0]         instr;
    logic                    memEn;
    logic                    memWe;
    logic [XLen-1:0]         memAddr;
    logic [XLen-1:0]         memWdata;
    logic [XLen-1:0]         memRdata;
    logic [XLen-1:0]         wbPc;
    logic                    wbWen;
    logic [RegAddrWidth-1:0] wbWnum;
    logic [XLen-1:0]         wbWdata;

    logic [XLen-1:0] golden [0:1023];
    logic [XLen-1:0] imem [0:255];
    logic [XLen-1:0] dmem [0:255];

    int seed        = 9169;
    int numEntries  = 0;
    int evIdx       = 0;   // next trace entry to match
    int errors      = 0;
    int testErrors  = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    bit timedOut    = 1'b0;

    logic [XLen-1:0] heldAddr;
    bit              pcHeld      = 1'b0;
    int              stallCycles = 0;

    mipsCore #(.ResetPc(ResetPc)) DUT (
        .clk(clk), .rstN_i(rstN),
        .instAddr_o(instAddr), .instEn_o(instEn), .instr_i(instr),
        .memEn_o(memEn), .memWe_o(memWe), .memAddr_o(memAddr),
        .memWdata_o(memWdata), .memRdata_i(memRdata),
        .wbPc_o(wbPc), .wbWen_o(wbWen), .wbWnum_o(wbWnum), .wbWdata_o(wbWdata)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // both memories answer in the same cycle
    assign instr    = imem[instAddr[9:2]];
    assign memRdata = dmem[memAddr[9:2]];

    always @(posedge clk) begin
        if (memWe) begin
            dmem[memAddr[9:2]] <= memWdata;
        end
    end

    function automatic string testName(input int n);
        case (n)
            1:       return "alu and immediates";
            2:       return "forwarding";
            3:       return "load-use";
            4:       return "store then load";
            5:       return "branches and jump";
            default: return "unknown";
        endcase
    endfunction

    // rd for the special opcode, rt for the immediate forms
    function automatic logic [RegAddrWidth-1:0] destOf(input logic [XLen-1:0] word);
        return (word[31:26] == OpSpecial) ? word[15:11] : word[20:16];
    endfunction

    task automatic reportTest(input string name, input int errs);
        if (errs == 0) begin
            $display("test %s: passed", name);
            testsPassed++;
        end else begin
            $display("test %s: failed with %0d errors", name, errs);
            testsFailed++;
        end
    endtask

    // an end marker in the list closes the test before it
    task automatic closeTests();
        int n;
        while (evIdx < numEntries && golden[EventBase + 3 * evIdx] == 3) begin
            n = golden[EventBase + 3 * evIdx + 1];
            reportTest(testName(n), testErrors);
            testErrors = 0;
            evIdx++;
        end
    endtask

    task automatic matchEvent(input int kind, input logic [XLen-1:0] key,
                              input logic [XLen-1:0] value);
        logic [XLen-1:0] expKind;
        logic [XLen-1:0] expKey;
        logic [XLen-1:0] expVal;
        string           what;
        int              base;
        what = (kind == 1) ? "register write" : "store";
        if (evIdx >= numEntries) begin
            $display("unexpected %s at time %0t after the whole trace was seen", what, $time);
            errors++;
            return;
        end
        base    = EventBase + 3 * evIdx;
        expKind = golden[base];
        expKey  = golden[base + 1];
        expVal  = golden[base + 2];
        assert (expKind == kind) else begin
            $display("[FAIL] %0t: %s came where the trace expects another kind of event",
                     $time, what);
            errors++;
            testErrors++;
        end
        if (expKind == kind) begin
            assert (key == expKey && value == expVal) else begin
                $display("[FAIL] %0t: %s to %h with %h, expected %h with %h",
                         $time, what, key, value, expKey, expVal);
                errors++;
                testErrors++;
            end
        end
        evIdx++;
        closeTests();
    endtask

    // the retiring pc must hold an instruction that writes this register
    task automatic checkWbPc();
        logic [XLen-1:0] word;
        word = imem[wbPc[9:2]];
        assert (wbPc[XLen-1:10] == ResetPc[XLen-1:10] && wbPc[1:0] == 2'b00
                && destOf(word) == wbWnum) else begin
            $display("[FAIL] %0t: write to register %0d reported from pc %h holding %h",
                     $time, wbWnum, wbPc, word);
            errors++;
            testErrors++;
        end
    endtask

    // a stalled fetch keeps its address for one more cycle
    task automatic checkFetchHold();
        if (pcHeld) begin
            assert (instAddr == heldAddr) else begin
                $display("[FAIL] %0t: fetch address %h moved away from stalled %h",
                         $time, instAddr, heldAddr);
                errors++;
                testErrors++;
            end
        end
        pcHeld   = !instEn;
        heldAddr = instAddr;
        if (!instEn) begin
            stallCycles++;
        end
    endtask

    // outputs are sampled before the edge updates them
    always @(posedge clk) begin
        if (rstN) begin
            if (wbWen) begin
                checkWbPc();
                matchEvent(1, XLen'(wbWnum), wbWdata);   // older instruction first
            end
            if (memWe) begin
                matchEvent(2, memAddr, memWdata);
            end
            checkFetchHold();
        end
    end

    task automatic loadImages();
        for (int k = 0; k < 1024; k++) begin
            golden[k] = '0;
        end
        $readmemh("verif/golden_program.txt", golden);
        for (int k = 0; k < 256; k++) begin
            imem[k] = golden[k];
            if (k < DataWords) begin
                dmem[k] = golden[DataBase + k];
            end else begin
                dmem[k] = $random(seed);   // noise, so a stray load shows up
            end
        end
        while (numEntries < MaxEntries && golden[EventBase + 3 * numEntries] != '0) begin
            numEntries++;
        end
        if (numEntries == 0) begin
            $display("the golden file holds no trace entries");
            errors++;
        end
    endtask

    task automatic checkResetState();
        int errs;
        errs = 0;
        assert (!wbWen && !memWe && !memEn && instAddr == ResetPc) else begin
            $display("[FAIL] %0t: reset state wbWen=%b memWe=%b memEn=%b instAddr=%h",
                     $time, wbWen, memWe, memEn, instAddr);
            errs++;
        end
        errors += errs;
        reportTest("reset state", errs);
    endtask

    task automatic checkStallCount();
        int errs;
        errs = 0;
        assert (stallCycles == LoadUseStalls) else begin
            $display("[FAIL] %0t: fetch stalled for %0d cycles, expected %0d",
                     $time, stallCycles, LoadUseStalls);
            errs++;
        end
        errors += errs;
        reportTest("load-use stall count", errs);
    endtask

    initial begin
        int cycles;
        rstN = 1'b0;
        loadImages();
        repeat (3) @(posedge clk);
        checkResetState();
        rstN <= 1'b1;
        cycles = 0;
        while (evIdx < numEntries && cycles < TimeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (evIdx < numEntries) begin
            $display("timeout: the core stopped at trace entry %0d of %0d after %0d cycles",
                     evIdx, numEntries, cycles);
            timedOut = 1'b1;
            testsFailed++;   // the test in progress
        end else begin
            // a duplicated event would land in this quiet window
            cycles = 0;
            while (cycles < DrainCycles) begin
                @(posedge clk);
                cycles++;
            end
            checkStallCount();
        end
        $display("tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errors);
        if (errors == 0 && testsFailed == 0 && !timedOut) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verif/golden_program.txt */
// @000 program words, @100 initial data words, @200 trace entries
// trace entry columns: kind (1 reg write, 2 store, 3 end of test n), reg or addr, value
@000
// alu and immediates, two writes to $0
3C011234 2402FFFB 34038001 3044F0F0 24000007 2845FFFC 28660100 00233821
00614023 00E44824 00245025 00435826 0040602A 00036900 00220021
// forwarding from E, M and W
240E000A 01CE7821 24100003 01F08823 34120055 00000000 02329826 026EA021
24150001 26B50002 02B5B021
// load-use
8C170000 02F7C021 8C190004 8C1A0008 0359D82A 8C1C000C 00000000 279D0001
// store then load
AC180010 8C1E0010 24010077 AC010014 8C020014
// branches with delay slots, jump, then a jump to itself
24030001 10630002 24040011 24050BAD 14600002 24060022 24070BAD 10600002
24080033 24090044 0BF00034 240A0055 240B0BAD 240C0066 0BF00035 00000000
@100
5A3C96E1 0F1E2D3C 80000007 13579BDF
@200
1 01 12340000  1 02 FFFFFFFB  1 03 00008001  1 04 0000F0F0
1 05 00000001  1 06 00000000  1 07 12348001  1 08 EDCC8001
1 09 00008000  1 0A 1234F0F0  1 0B FFFF7FFA  1 0C 00000001
1 0D 00080010  3 01 00000000
1 0E 0000000A  1 0F 00000014  1 10 00000003  1 11 00000011
1 12 00000055  1 13 00000044  1 14 0000004E  1 15 00000001
1 15 00000003  1 16 00000006  3 02 00000000
1 17 5A3C96E1  1 18 B4792DC2  1 19 0F1E2D3C  1 1A 80000007
1 1B 00000001  1 1C 13579BDF  1 1D 13579BE0  3 03 00000000
2 10 B4792DC2  1 1E B4792DC2  1 01 00000077  2 14 00000077
1 02 00000077  3 04 00000000
1 03 00000001  1 04 00000011  1 06 00000022  1 08 00000033
1 09 00000044  1 0A 00000055  1 0C 00000066  3 05 00000000
0 0 0

/* all.f */
hw/mipsPkg.sv
hw/regFile.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/hazardUnit.sv
hw/mipsCore.sv
verif/tbMipsCore.sv

/* Bender.yml */
package:
  name: mipsCore

sources:
  - hw/mipsPkg.sv
  - hw/regFile.sv
  - hw/fetchStage.sv
  - hw/decodeStage.sv
  - hw/executeStage.sv
  - hw/memoryStage.sv
  - hw/hazardUnit.sv
  - hw/mipsCore.sv
  - target: simulation
    files:
      - verif/tbMipsCore.sv
